// ==== design/settings_pkg.sv ====
package settings_pkg;

    // --------------------------------------------------
    // Bus geometry
    // --------------------------------------------------
    localparam int WORD_W = 16;
    localparam int ADDR_W = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    localparam int READ_LATENCY = 2; // Address to read data, in cycles

    // --------------------------------------------------
    // Control memory map
    // --------------------------------------------------
    localparam addr_t ADDR_CTL_FLAG      = 8'h00;
    localparam addr_t ADDR_FPGA_STATE    = 8'h01;
    localparam addr_t ADDR_VERSION_MAJOR = 8'h02;
    localparam addr_t ADDR_VERSION_MINOR = 8'h03;

    localparam addr_t ADDR_SILENCER_BASE = 8'h40;
    localparam addr_t ADDR_SYNC_BASE     = 8'h50;

    localparam int SILENCER_WORDS = 5;
    localparam int SYNC_WORDS     = 4;
    localparam int BLOCK_IDX_W    = 3; // Wide enough for the longest block

    // Control flag word
    localparam int FLAG_BIT_SILENCER_SET = 0;
    localparam int FLAG_BIT_SYNC_SET     = 1;
    localparam int FLAG_BIT_FORCE_FAN    = 4;
    localparam int FLAG_BIT_GPIO_0       = 8;
    localparam int FLAG_BIT_GPIO_1       = 9;
    localparam int FLAG_BIT_GPIO_2       = 10;
    localparam int FLAG_BIT_GPIO_3       = 11;

    // FPGA state word, other bits read as zero
    localparam int STATE_BIT_THERMO         = 0;
    localparam int STATE_BIT_MOD_SEGMENT    = 1;
    localparam int STATE_BIT_STM_SEGMENT    = 2;
    localparam int STATE_BIT_STM_CYCLE_ZERO = 3;

    // Silencer wins when both flags are set
    typedef enum logic [0:0] {
        GROUP_SILENCER = 1'b0,
        GROUP_SYNC     = 1'b1
    } group_t;

    // --------------------------------------------------
    // Settings payloads
    // --------------------------------------------------
    // Last member is the low word, i.e. the first word read
    typedef struct packed {
        word_t completion_steps_phase;
        word_t completion_steps_intensity;
        word_t update_rate_phase;
        word_t update_rate_intensity;
        word_t flag;
    } silencer_settings_t;

    typedef struct packed {
        logic [63:0] ecat_sync_time;
    } sync_settings_t;

    localparam silencer_settings_t SILENCER_DEFAULT = '{
        completion_steps_phase:     16'd40,
        completion_steps_intensity: 16'd10,
        update_rate_phase:          16'd256,
        update_rate_intensity:      16'd256,
        flag:                       16'd0
    };

    localparam sync_settings_t SYNC_DEFAULT = '{ecat_sync_time: 64'd0};

endpackage

// ==== design/load_if.sv ====
// Read-back words from the sequencer, one per cycle, broadcast to all
// capture units; each unit filters on word_group
interface load_if;

    logic                 word_valid;
    settings_pkg::group_t word_group;
    settings_pkg::word_t  word_data;
    logic                 word_last; // Final word of the block

    modport source (
        output word_valid,
        output word_group,
        output word_data,
        output word_last
    );

    modport sink (
        input word_valid,
        input word_group,
        input word_data,
        input word_last
    );

endinterface

// ==== design/flag_arbiter.sv ====
module flag_arbiter (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 flag_load,
    input  settings_pkg::word_t  flag_in,
    input  logic                 grant,
    output logic                 pending,
    output settings_pkg::group_t pending_group,
    output settings_pkg::word_t  flags,
    output logic                 force_fan,
    output logic [3:0]           gpio_in
);

    logic                silencer_set;
    logic                sync_set;
    settings_pkg::word_t clr_mask;

    assign silencer_set = flags[settings_pkg::FLAG_BIT_SILENCER_SET];
    assign sync_set     = flags[settings_pkg::FLAG_BIT_SYNC_SET];

    // Fixed priority, silencer first
    assign pending       = silencer_set | sync_set;
    assign pending_group = silencer_set ? settings_pkg::GROUP_SILENCER : settings_pkg::GROUP_SYNC;

    always_comb begin
        clr_mask = '0;
        if (pending_group == settings_pkg::GROUP_SILENCER) begin
            clr_mask[settings_pkg::FLAG_BIT_SILENCER_SET] = 1'b1;
        end else begin
            clr_mask[settings_pkg::FLAG_BIT_SYNC_SET] = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            flags <= '0;
        end else if (flag_load) begin
            flags <= flag_in;
        end else if (grant) begin
            flags <= flags & ~clr_mask; // Drop the granted request only
        end
    end

    // Straight from the flag word
    assign force_fan  = flags[settings_pkg::FLAG_BIT_FORCE_FAN];
    assign gpio_in[0] = flags[settings_pkg::FLAG_BIT_GPIO_0];
    assign gpio_in[1] = flags[settings_pkg::FLAG_BIT_GPIO_1];
    assign gpio_in[2] = flags[settings_pkg::FLAG_BIT_GPIO_2];
    assign gpio_in[3] = flags[settings_pkg::FLAG_BIT_GPIO_3];

    // The sequencer only grants what was reported as pending
    a_grant_needs_pending: assert property (
        @(posedge CLK) disable iff (reset) grant |-> pending
    );

endmodule

// ==== design/load_sequencer.sv ====
module load_sequencer #(
    parameter logic [7:0] VERSION_MAJOR = 8'd1,
    parameter logic [7:0] VERSION_MINOR = 8'd0
) (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 thermo,
    input  logic                 mod_segment,
    input  logic                 stm_segment,
    input  settings_pkg::word_t  stm_cycle,
    output logic                 bus_we,
    output settings_pkg::addr_t  bus_addr,
    output settings_pkg::word_t  bus_din,
    input  settings_pkg::word_t  bus_dout,
    output logic                 flag_load,
    output logic                 grant,
    input  logic                 pending,
    input  settings_pkg::group_t pending_group,
    input  settings_pkg::word_t  flags,
    load_if.source               load
);

    typedef enum logic [2:0] {
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_POLL_RD,
        ST_POLL_WR,
        ST_BLOCK,
        ST_FLAG_WB,
        ST_STATE_WB
    } state_t;

    // What kind of read a bus cycle carried
    typedef struct packed {
        logic blk;
        logic last;
        logic flag;
    } tag_t;

    state_t                                state_q, state_d;
    logic [settings_pkg::BLOCK_IDX_W-1:0] cnt_q, cnt_d;
    settings_pkg::group_t                  grp_q, grp_d;
    logic                                  we_d;
    settings_pkg::addr_t                   addr_d;
    settings_pkg::word_t                   din_d;
    tag_t                                  tag_d;
    tag_t                                  issue_q;
    tag_t                                  pipe_q [settings_pkg::READ_LATENCY];
    settings_pkg::word_t                   state_word;
    settings_pkg::addr_t                   block_base;
    settings_pkg::addr_t                   block_len;

    always_comb begin
        state_word = '0;
        state_word[settings_pkg::STATE_BIT_THERMO]         = thermo;
        state_word[settings_pkg::STATE_BIT_MOD_SEGMENT]    = mod_segment;
        state_word[settings_pkg::STATE_BIT_STM_SEGMENT]    = stm_segment;
        state_word[settings_pkg::STATE_BIT_STM_CYCLE_ZERO] = (stm_cycle == '0);
    end

    assign block_base = (grp_q == settings_pkg::GROUP_SILENCER) ?
                        settings_pkg::ADDR_SILENCER_BASE : settings_pkg::ADDR_SYNC_BASE;
    assign block_len  = (grp_q == settings_pkg::GROUP_SILENCER) ?
                        settings_pkg::addr_t'(settings_pkg::SILENCER_WORDS) :
                        settings_pkg::addr_t'(settings_pkg::SYNC_WORDS);

    // Flags are only taken from a returning flag read
    assign grant     = (state_q == ST_POLL_WR) && pending;
    assign flag_load = (state_q == ST_POLL_WR) && !pending &&
                       pipe_q[settings_pkg::READ_LATENCY-1].flag;

    // --------------------------------------------------
    // Next bus cycle
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        grp_d   = grp_q;
        we_d    = 1'b0;
        addr_d  = settings_pkg::ADDR_CTL_FLAG;
        din_d   = state_word;
        tag_d   = '0;
        case (state_q)
            ST_VER_MINOR: begin
                we_d    = 1'b1;
                addr_d  = settings_pkg::ADDR_VERSION_MINOR;
                din_d   = settings_pkg::word_t'(VERSION_MINOR);
                state_d = ST_VER_MAJOR;
            end
            ST_VER_MAJOR: begin
                we_d    = 1'b1;
                addr_d  = settings_pkg::ADDR_VERSION_MAJOR;
                din_d   = settings_pkg::word_t'(VERSION_MAJOR);
                state_d = ST_POLL_RD;
            end
            ST_POLL_RD: begin
                tag_d.flag = 1'b1;
                state_d    = ST_POLL_WR;
            end
            ST_POLL_WR: begin
                we_d   = 1'b1;
                addr_d = settings_pkg::ADDR_FPGA_STATE;
                if (pending) begin
                    cnt_d   = '0;
                    grp_d   = pending_group;
                    state_d = ST_BLOCK;
                end else begin
                    state_d = ST_POLL_RD;
                end
            end
            ST_BLOCK: begin
                addr_d    = block_base + settings_pkg::addr_t'(cnt_q);
                tag_d.blk = 1'b1;
                if (settings_pkg::addr_t'(cnt_q) == block_len - 1'b1) begin
                    tag_d.last = 1'b1;
                    state_d    = ST_FLAG_WB;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            ST_FLAG_WB: begin
                we_d    = 1'b1;
                din_d   = flags; // Granted bit already cleared
                state_d = ST_STATE_WB;
            end
            ST_STATE_WB: begin
                we_d    = 1'b1;
                addr_d  = settings_pkg::ADDR_FPGA_STATE;
                state_d = ST_POLL_RD;
            end
            default: state_d = ST_POLL_RD;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state_q <= ST_VER_MINOR;
            cnt_q   <= '0;
            grp_q   <= settings_pkg::GROUP_SILENCER;
            bus_we  <= 1'b0;
            issue_q <= '0;
            for (int i = 0; i < settings_pkg::READ_LATENCY; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            state_q   <= state_d;
            cnt_q     <= cnt_d;
            grp_q     <= grp_d;
            bus_we    <= we_d;
            issue_q   <= tag_d;
            pipe_q[0] <= issue_q; // Tag follows the bus cycle to its data
            for (int i = 1; i < settings_pkg::READ_LATENCY; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    always_ff @(posedge CLK) begin
        bus_addr <= addr_d;
        bus_din  <= din_d;
    end

    assign load.word_valid = pipe_q[settings_pkg::READ_LATENCY-1].blk;
    assign load.word_last  = pipe_q[settings_pkg::READ_LATENCY-1].last;
    assign load.word_group = grp_q;
    assign load.word_data  = bus_dout;

    // Block reads stay inside the granted group's range
    a_read_in_block: assert property (
        @(posedge CLK) disable iff (reset)
        issue_q.blk |-> !bus_we && ((bus_addr - block_base) < block_len)
    );

endmodule

// ==== design/settings_capture.sv ====
module settings_capture #(
    parameter type                  payload_t = logic [31:0],
    parameter settings_pkg::group_t GROUP     = settings_pkg::GROUP_SILENCER,
    parameter payload_t             DEFAULT   = '0
) (
    input  logic     CLK,
    input  logic     reset,
    load_if.sink     load,
    output payload_t settings,
    output logic     update
);

    localparam int PAYLOAD_W = $bits(payload_t);

    logic [PAYLOAD_W-1:0] staging_q;
    logic [PAYLOAD_W-1:0] staging_d;
    logic                 take;

    assign take = load.word_valid && (load.word_group == GROUP);

    // New word enters at the top and moves down, first word ends lowest
    assign staging_d = {load.word_data, staging_q[PAYLOAD_W-1:settings_pkg::WORD_W]};

    always_ff @(posedge CLK) begin
        if (take) begin
            staging_q <= staging_d;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            settings <= DEFAULT;
            update   <= 1'b0;
        end else begin
            update <= take && load.word_last;
            if (take && load.word_last) begin
                settings <= payload_t'(staging_d); // Whole group at once
            end
        end
    end

    a_update_single: assert property (
        @(posedge CLK) disable iff (reset) update |=> !update
    );

endmodule

// ==== design/settings_ctrl_top.sv ====
module settings_ctrl_top #(
    parameter logic [7:0] VERSION_MAJOR = 8'd1,
    parameter logic [7:0] VERSION_MINOR = 8'd0
) (
    input  logic                             CLK,
    input  logic                             reset,
    input  logic                             thermo,
    input  logic                             mod_segment,
    input  logic                             stm_segment,
    input  settings_pkg::word_t              stm_cycle,
    output logic                             bus_we,
    output settings_pkg::addr_t              bus_addr,
    output settings_pkg::word_t              bus_din,
    input  settings_pkg::word_t              bus_dout,
    output settings_pkg::silencer_settings_t silencer_settings,
    output logic                             silencer_update,
    output settings_pkg::sync_settings_t     sync_settings,
    output logic                             sync_update,
    output logic                             force_fan,
    output logic [3:0]                       gpio_in
);

    logic                 flag_load;
    logic                 grant;
    logic                 pending;
    settings_pkg::group_t pending_group;
    settings_pkg::word_t  flags;

    load_if load_bus ();

    flag_arbiter u_arbiter (
        .CLK           (CLK),
        .reset         (reset),
        .flag_load     (flag_load),
        .flag_in       (bus_dout),
        .grant         (grant),
        .pending       (pending),
        .pending_group (pending_group),
        .flags         (flags),
        .force_fan     (force_fan),
        .gpio_in       (gpio_in)
    );

    load_sequencer #(
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR)
    ) u_sequencer (
        .CLK           (CLK),
        .reset         (reset),
        .thermo        (thermo),
        .mod_segment   (mod_segment),
        .stm_segment   (stm_segment),
        .stm_cycle     (stm_cycle),
        .bus_we        (bus_we),
        .bus_addr      (bus_addr),
        .bus_din       (bus_din),
        .bus_dout      (bus_dout),
        .flag_load     (flag_load),
        .grant         (grant),
        .pending       (pending),
        .pending_group (pending_group),
        .flags         (flags),
        .load          (load_bus.source)
    );

    // --------------------------------------------------
    // One capture unit per settings group
    // --------------------------------------------------
    settings_capture #(
        .payload_t (settings_pkg::silencer_settings_t),
        .GROUP     (settings_pkg::GROUP_SILENCER),
        .DEFAULT   (settings_pkg::SILENCER_DEFAULT)
    ) u_silencer (
        .CLK      (CLK),
        .reset    (reset),
        .load     (load_bus.sink),
        .settings (silencer_settings),
        .update   (silencer_update)
    );

    settings_capture #(
        .payload_t (settings_pkg::sync_settings_t),
        .GROUP     (settings_pkg::GROUP_SYNC),
        .DEFAULT   (settings_pkg::SYNC_DEFAULT)
    ) u_sync (
        .CLK      (CLK),
        .reset    (reset),
        .load     (load_bus.sink),
        .settings (sync_settings),
        .update   (sync_update)
    );

endmodule

// ==== dv/tb_settings_ctrl.sv ====
module tb_settings_ctrl;

    localparam logic [7:0] VER_MAJOR      = 8'd3;
    localparam logic [7:0] VER_MINOR      = 8'd14;
    localparam int         TIMEOUT_CYCLES = 200;
    localparam int         ITERATIONS     = 20;

    logic                             CLK;
    logic                             reset;
    logic                             thermo;
    logic                             mod_segment;
    logic                             stm_segment;
    settings_pkg::word_t              stm_cycle;
    logic                             bus_we;
    settings_pkg::addr_t              bus_addr;
    settings_pkg::word_t              bus_din;
    settings_pkg::word_t              bus_dout;
    settings_pkg::silencer_settings_t silencer_settings;
    logic                             silencer_update;
    settings_pkg::sync_settings_t     sync_settings;
    logic                             sync_update;
    logic                             force_fan;
    logic [3:0]                       gpio_in;

    settings_pkg::word_t mem [256];
    settings_pkg::word_t rd_q0;
    settings_pkg::word_t rd_q1;
    logic                host_we;
    settings_pkg::addr_t host_addr;
    settings_pkg::word_t host_data;

    logic [31:0]                      rng;
    int                               checks;
    int                               value_errors;
    int                               other_errors;
    int                               cycle = 0;
    int                               sil_pulses = 0;
    int                               sync_pulses = 0;
    int                               sil_pulse_cycle = 0;
    int                               sync_pulse_cycle = 0;
    int                               exp_sil_pulses;
    int                               exp_sync_pulses;
    settings_pkg::word_t              block_words [5];
    settings_pkg::silencer_settings_t exp_sil;
    settings_pkg::sync_settings_t     exp_sync;

    settings_ctrl_top #(
        .VERSION_MAJOR (VER_MAJOR),
        .VERSION_MINOR (VER_MINOR)
    ) uut (
        .CLK               (CLK),
        .reset             (reset),
        .thermo            (thermo),
        .mod_segment       (mod_segment),
        .stm_segment       (stm_segment),
        .stm_cycle         (stm_cycle),
        .bus_we            (bus_we),
        .bus_addr          (bus_addr),
        .bus_din           (bus_din),
        .bus_dout          (bus_dout),
        .silencer_settings (silencer_settings),
        .silencer_update   (silencer_update),
        .sync_settings     (sync_settings),
        .sync_update       (sync_update),
        .force_fan         (force_fan),
        .gpio_in           (gpio_in)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // --------------------------------------------------
    // Control memory model with two-cycle read
    // --------------------------------------------------
    always @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {i[7:0] ^ 8'h5A, ~i[7:0]};
            end
            mem[settings_pkg::ADDR_CTL_FLAG] <= '0; // No request pending at start
            rd_q0 <= '0;
            rd_q1 <= '0;
        end else begin
            if (bus_we) begin
                mem[bus_addr] <= bus_din;
            end
            if (host_we) begin
                mem[host_addr] <= host_data;
            end
            rd_q0 <= mem[bus_addr];
            rd_q1 <= rd_q0;
        end
    end

    assign bus_dout = rd_q1;

    // Update pulse counters
    always @(posedge CLK) begin
        cycle <= cycle + 1;
        if (!reset && silencer_update) begin
            sil_pulses      <= sil_pulses + 1;
            sil_pulse_cycle <= cycle;
        end
        if (!reset && sync_update) begin
            sync_pulses      <= sync_pulses + 1;
            sync_pulse_cycle <= cycle;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic settings_pkg::word_t random_word();
        rng = xorshift32(rng);
        return rng[15:0];
    endfunction

    // Bits 0 to 3 hold thermo, mod segment, stm segment and zero cycle count
    function automatic settings_pkg::word_t expected_state();
        return {12'd0, (stm_cycle == 16'd0), stm_segment, mod_segment, thermo};
    endfunction

    task automatic compare_word(input string what, input settings_pkg::word_t got,
                                input settings_pkg::word_t expected);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic compare_silencer(input string what,
                                    input settings_pkg::silencer_settings_t got,
                                    input settings_pkg::silencer_settings_t expected);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic compare_sync(input string what, input settings_pkg::sync_settings_t got,
                                input settings_pkg::sync_settings_t expected);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic compare_count(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            value_errors++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, expected);
        end
    endtask

    // --------------------------------------------------
    // Bounded waits
    // --------------------------------------------------
    task automatic wait_mem(input settings_pkg::addr_t addr, input settings_pkg::word_t mask,
                            input settings_pkg::word_t value, input string what);
        int n;
        n = 0;
        while (((mem[addr] & mask) != value) && n < TIMEOUT_CYCLES) begin
            @(negedge CLK);
            n++;
        end
        if ((mem[addr] & mask) != value) begin
            other_errors++;
            $display("ERROR at %0t: timed out waiting for %s", $time, what);
        end
    endtask

    task automatic wait_pulses(input int sil_target, input int sync_target);
        int n;
        n = 0;
        while ((sil_pulses < sil_target || sync_pulses < sync_target) && n < TIMEOUT_CYCLES) begin
            @(negedge CLK);
            n++;
        end
        if (sil_pulses < sil_target || sync_pulses < sync_target) begin
            other_errors++;
            $display("ERROR at %0t: timed out waiting for an update pulse", $time);
        end
    endtask

    task automatic wait_fan_gpio(input logic [4:0] expected);
        int n;
        n = 0;
        while ({gpio_in, force_fan} != expected && n < TIMEOUT_CYCLES) begin
            @(negedge CLK);
            n++;
        end
        if ({gpio_in, force_fan} != expected) begin
            other_errors++;
            $display("ERROR at %0t: timed out waiting for force_fan and gpio_in", $time);
        end
    endtask

    // Host port writes one word per falling edge
    task automatic write_host(input settings_pkg::addr_t addr, input settings_pkg::word_t data);
        host_we   = 1'b1;
        host_addr = addr;
        host_data = data;
        @(negedge CLK);
        host_we = 1'b0;
    endtask

    task automatic fill_block(input settings_pkg::addr_t base, input int count);
        for (int i = 0; i < count; i++) begin
            block_words[i] = random_word();
            write_host(base + settings_pkg::addr_t'(i), block_words[i]);
        end
    endtask

    task automatic set_status();
        settings_pkg::word_t r;
        r           = random_word();
        thermo      = r[0];
        mod_segment = r[1];
        stm_segment = r[2];
        stm_cycle   = r[3] ? 16'd0 : random_word(); // Zero count about half the time
    endtask

    initial begin
        logic [1:0]          kind;
        logic [4:0]          fan_gpio;
        settings_pkg::word_t r;
        settings_pkg::word_t flag_word;
        settings_pkg::word_t set_mask;
        reset           = 1'b1;
        thermo          = 1'b0;
        mod_segment     = 1'b0;
        stm_segment     = 1'b0;
        stm_cycle       = '0;
        host_we         = 1'b0;
        host_addr       = '0;
        host_data       = '0;
        rng             = 32'd59135;
        checks          = 0;
        value_errors    = 0;
        other_errors    = 0;
        exp_sil_pulses  = 0;
        exp_sync_pulses = 0;
        set_mask        = '0;
        set_mask[settings_pkg::FLAG_BIT_SILENCER_SET] = 1'b1;
        set_mask[settings_pkg::FLAG_BIT_SYNC_SET]     = 1'b1;
        repeat (10) @(negedge CLK);
        reset = 1'b0;

        // Defaults after reset
        exp_sil.flag                       = 16'd0;
        exp_sil.update_rate_intensity      = 16'd256;
        exp_sil.update_rate_phase          = 16'd256;
        exp_sil.completion_steps_intensity = 16'd10;
        exp_sil.completion_steps_phase     = 16'd40;
        exp_sync.ecat_sync_time            = 64'd0;
        compare_silencer("silencer after reset", silencer_settings, exp_sil);
        compare_sync("sync after reset", sync_settings, exp_sync);
        compare_word("updates after reset", {14'd0, sync_update, silencer_update}, 16'd0);

        wait_mem(settings_pkg::ADDR_VERSION_MAJOR, 16'hFFFF, {8'd0, VER_MAJOR}, "version write");
        compare_word("minor version", mem[settings_pkg::ADDR_VERSION_MINOR], {8'd0, VER_MINOR});
        compare_word("major version", mem[settings_pkg::ADDR_VERSION_MAJOR], {8'd0, VER_MAJOR});

        set_status();
        wait_mem(settings_pkg::ADDR_FPGA_STATE, 16'hFFFF, expected_state(), "state word");
        compare_word("state word", mem[settings_pkg::ADDR_FPGA_STATE], expected_state());

        for (int it = 0; it < ITERATIONS; it++) begin
            r = random_word();
            if (it < 3) begin
                kind = (it == 0) ? 2'b01 : ((it == 1) ? 2'b10 : 2'b11);
            end else begin
                kind = r[1:0];
            end
            fan_gpio = r[6:2]; // gpio_in[3:0] above force_fan
            set_status();
            flag_word = '0;
            flag_word[settings_pkg::FLAG_BIT_FORCE_FAN] = fan_gpio[0];
            flag_word[settings_pkg::FLAG_BIT_GPIO_0]    = fan_gpio[1];
            flag_word[settings_pkg::FLAG_BIT_GPIO_1]    = fan_gpio[2];
            flag_word[settings_pkg::FLAG_BIT_GPIO_2]    = fan_gpio[3];
            flag_word[settings_pkg::FLAG_BIT_GPIO_3]    = fan_gpio[4];
            if (kind[0]) begin
                fill_block(settings_pkg::ADDR_SILENCER_BASE, settings_pkg::SILENCER_WORDS);
                exp_sil.flag                       = block_words[0];
                exp_sil.update_rate_intensity      = block_words[1];
                exp_sil.update_rate_phase          = block_words[2];
                exp_sil.completion_steps_intensity = block_words[3];
                exp_sil.completion_steps_phase     = block_words[4];
                exp_sil_pulses++;
                flag_word[settings_pkg::FLAG_BIT_SILENCER_SET] = 1'b1;
            end
            if (kind[1]) begin
                fill_block(settings_pkg::ADDR_SYNC_BASE, settings_pkg::SYNC_WORDS);
                exp_sync.ecat_sync_time = {block_words[3], block_words[2],
                                           block_words[1], block_words[0]};
                exp_sync_pulses++;
                flag_word[settings_pkg::FLAG_BIT_SYNC_SET] = 1'b1;
            end
            write_host(settings_pkg::ADDR_CTL_FLAG, flag_word);

            wait_pulses(exp_sil_pulses, exp_sync_pulses);
            if (kind == 2'b11 && sil_pulse_cycle >= sync_pulse_cycle) begin
                other_errors++;
                $display("ERROR at %0t: sync update did not follow silencer update", $time);
            end
            wait_mem(settings_pkg::ADDR_CTL_FLAG, set_mask, '0, "flag bits to clear");
            compare_word("flag set bits", mem[settings_pkg::ADDR_CTL_FLAG] & set_mask, '0);
            wait_fan_gpio(fan_gpio);
            compare_word("force_fan and gpio_in", {11'd0, gpio_in, force_fan}, {11'd0, fan_gpio});
            wait_mem(settings_pkg::ADDR_FPGA_STATE, 16'hFFFF, expected_state(), "state word");
            compare_word("state word", mem[settings_pkg::ADDR_FPGA_STATE], expected_state());
            compare_silencer("silencer settings", silencer_settings, exp_sil);
            compare_sync("sync settings", sync_settings, exp_sync);
            compare_count("silencer pulses", sil_pulses, exp_sil_pulses);
            compare_count("sync pulses", sync_pulses, exp_sync_pulses);
        end

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/settings_pkg.sv
design/load_if.sv
design/flag_arbiter.sv
design/load_sequencer.sv
design/settings_capture.sv
design/settings_ctrl_top.sv
dv/tb_settings_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_settings_ctrl -f src.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "All checks passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
